// File: all.f
+incdir+include
rtl/mavg_pkg.sv
rtl/mavg_cmd_issue.sv
rtl/mavg_window.sv
rtl/mavg_averager.sv
rtl/mavg_top.sv
sim/mavg_clkgen.sv
sim/mavg_asserts.sv
sim/mavg_tb.sv

// File: sim/mavg_tb.sv
`include "mavg_consts.svh"

module mavg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CMDS   = 30;
    localparam int MAX_CYCLES = NUM_CMDS * (17 * 8 + 40);  // Worst burst plus slack for each command

    logic                  clk;
    logic                  rst_q;
    logic                  cmd_valid;
    mavg_pkg::mavg_cmd_t   cmd;
    logic                  cmd_rdy;
    mavg_pkg::mavg_burst_t ar_req;
    mavg_pkg::mavg_burst_t aw_req;
    logic                  ar_valid;
    logic                  ar_ready;
    logic                  aw_valid;
    logic                  aw_ready;
    mavg_pkg::mavg_beat_t  rd;
    mavg_pkg::mavg_beat_t  wr;
    logic                  rvalid;
    logic                  rready;
    logic                  wvalid;
    logic                  wready;

    mavg_pkg::mavg_burst_t  exp_ar_q[$];   // One per accepted command
    mavg_pkg::mavg_burst_t  exp_aw_q[$];
    logic [`MAVG_LEN_W-1:0] rd_len_q[$];   // Granted read bursts awaiting data
    mavg_pkg::mavg_beat_t   exp_w_q[$];    // Model averages in read order
    int total_beats;
    int ar_seen;
    int aw_seen;
    int w_seen;
    int cycles;

    mavg_clkgen u_clkgen (.clk(clk), .rst_q(rst_q));

    mavg_top DUT (
        .clk(clk), .rst_q(rst_q),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_rdy(cmd_rdy),
        .ar_req(ar_req), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .aw_req(aw_req), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .rd(rd), .rvalid(rvalid), .rready(rready),
        .wr(wr), .wvalid(wvalid), .wready(wready)
    );

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory side responders driven at +2 ns and sampled at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic serve_addr();
        forever begin
            @(posedge clk);
            #2;
            ar_ready = ($urandom % 3) != 0;
            aw_ready = ($urandom % 3) != 0;
            @(negedge clk);
            if (ar_valid && ar_ready) begin     // Transfer on the coming edge
                check(exp_ar_q.size() > 0, 1, "AR request with no command behind it");
                check(ar_req, exp_ar_q.pop_front(), "AR request");
                rd_len_q.push_back(ar_req.len);
                ar_seen++;
            end
            if (aw_valid && aw_ready) begin
                check(exp_aw_q.size() > 0, 1, "AW request with no command behind it");
                check(aw_req, exp_aw_q.pop_front(), "AW request");
                aw_seen++;
            end
        end
    endtask

    // Read beats and the averaging model fed by the same accepted beats
    task automatic serve_read();
        logic [`MAVG_LEN_W-1:0]                 len;
        logic [`MAVG_DATA_W-1:0]                hist[`MAVG_WIN_LEN];
        logic [`MAVG_DATA_W+`MAVG_WIN_LOG2-1:0] sum;
        logic [`MAVG_DATA_W+`MAVG_WIN_LOG2-1:0] quot;
        forever begin
            wait (rd_len_q.size() > 0);
            len = rd_len_q.pop_front();
            for (int i = 0; i < `MAVG_WIN_LEN; i++) begin
                hist[i] = '0;                   // Before the burst counts as zero
            end
            for (int k = 0; k <= len; k++) begin
                @(posedge clk);
                #2;
                while (($urandom % 4) == 0) begin   // Random rvalid gap
                    rvalid = 1'b0;
                    @(posedge clk);
                    #2;
                end
                rd = '{data: $urandom, last: (k == len)};
                rvalid = 1'b1;
                @(negedge clk);
                while (!rready) @(negedge clk);
                for (int i = `MAVG_WIN_LEN - 1; i > 0; i--) begin
                    hist[i] = hist[i-1];
                end
                hist[0] = rd.data;
                sum = '0;
                for (int i = 0; i < `MAVG_WIN_LEN; i++) begin
                    sum = sum + hist[i];
                end
                quot = sum / `MAVG_WIN_LEN;     // Floor of the mean
                exp_w_q.push_back('{data: quot[`MAVG_DATA_W-1:0], last: rd.last});
            end
            @(posedge clk);
            #2 rvalid = 1'b0;
        end
    endtask

    task automatic collect_writes();
        mavg_pkg::mavg_beat_t exp_beat;
        forever begin
            @(posedge clk);
            #2 wready = ($urandom % 3) != 0;
            @(negedge clk);
            if (wvalid && wready) begin
                check(exp_w_q.size() > 0, 1, "write beat with no read beat behind it");
                exp_beat = exp_w_q.pop_front();
                check(wr.data, exp_beat.data, "write data");
                check(wr.last, exp_beat.last, "write last");
                w_seen++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Commands and end of run
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        mavg_pkg::mavg_cmd_t   c;
        mavg_pkg::mavg_burst_t req;
        int                    beats;
        void'($urandom(32'h4c2c_7b83));
        cmd_valid = 1'b0;
        cmd       = '0;
        ar_ready  = 1'b0;
        aw_ready  = 1'b0;
        rd        = '0;
        rvalid    = 1'b0;
        wready    = 1'b0;
        total_beats = 0;
        ar_seen     = 0;
        aw_seen     = 0;
        w_seen      = 0;
        @(negedge clk);
        while (rst_q) @(negedge clk);
        check(cmd_rdy, 1, "cmd_rdy after reset");
        check(rready, 1, "rready after reset");
        check({ar_valid, aw_valid, wvalid, wr.last}, 0, "valids and last after reset");
        fork
            serve_addr();
            serve_read();
            collect_writes();
        join_none
        for (int n = 0; n < NUM_CMDS; n++) begin
            @(posedge clk);
            #2;
            c.src_addr = $urandom;
            c.dst_addr = $urandom;
            c.size     = (($urandom % 16) + 1) * 4;     // 4 to 64 bytes
            cmd       = c;
            cmd_valid = 1'b1;                           // Held until taken
            @(negedge clk);
            while (!cmd_rdy) @(negedge clk);
            beats    = c.size >> `MAVG_BEAT_LOG2;
            req.addr = c.src_addr;
            req.len  = `MAVG_LEN_W'(beats - 1);
            exp_ar_q.push_back(req);
            req.addr = c.dst_addr;
            exp_aw_q.push_back(req);
            total_beats += beats;
            @(posedge clk);
            #2 cmd_valid = 1'b0;
            @(negedge clk);
            check(cmd_rdy, 0, "cmd_rdy right after command accepted");
            repeat ($urandom % 4) @(posedge clk);
        end
        wait (ar_seen == NUM_CMDS && aw_seen == NUM_CMDS && w_seen == total_beats);
        repeat (20) @(posedge clk);     // Room for any stray extra beat
        @(negedge clk);
        check({cmd_rdy, rready}, 2'b11, "cmd_rdy and rready after last burst");
        check({ar_valid, aw_valid, wvalid}, 0, "valids after last burst");
        $display("Simulation passed");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run timed out after %0d cycles without finishing", cycles);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// File: sim/mavg_asserts.sv
module mavg_asserts (
    input logic                  clk,
    input logic                  rst_q,
    input logic                  cmd_valid,
    input logic                  cmd_rdy,
    input mavg_pkg::mavg_burst_t ar_req,
    input logic                  ar_valid,
    input logic                  ar_ready,
    input mavg_pkg::mavg_burst_t aw_req,
    input logic                  aw_valid,
    input logic                  aw_ready,
    input mavg_pkg::mavg_beat_t  wr,
    input logic                  wvalid,
    input logic                  wready
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // Valid and payload hold until ready
    ////////////////////////////////////////////////////////////////////////////

    ar_hold: assert property (@(posedge clk) disable iff (rst_q)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_req))
        else $error("AR request changed or dropped before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (rst_q)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_req))
        else $error("AW request changed or dropped before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (rst_q)
        wvalid && !wready |=> wvalid && $stable(wr))
        else $error("Write beat changed or dropped before wready");

    // A taken command puts out both address requests
    cmd_issue: assert property (@(posedge clk) disable iff (rst_q)
        cmd_valid && cmd_rdy |=> ar_valid && aw_valid)
        else $error("Command taken without both address requests going out");

endmodule

bind mavg_top mavg_asserts u_asserts (
    .clk(clk), .rst_q(rst_q), .cmd_valid(cmd_valid), .cmd_rdy(cmd_rdy),
    .ar_req(ar_req), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .aw_req(aw_req), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .wr(wr), .wvalid(wvalid), .wready(wready)
);

// File: sim/mavg_clkgen.sv
module mavg_clkgen (
    output logic clk,
    output logic rst_q
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // Held over five rising edges, released just after the last one
    initial begin
        rst_q = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_q = 1'b0;
    end

endmodule

// File: rtl/mavg_top.sv
`include "mavg_consts.svh"

module mavg_top (
    input  logic                  clk,
    input  logic                  rst_q,

    // Command stream
    input  logic                  cmd_valid,
    input  mavg_pkg::mavg_cmd_t   cmd,
    output logic                  cmd_rdy,

    // Read address channel
    output mavg_pkg::mavg_burst_t ar_req,
    output logic                  ar_valid,
    input  logic                  ar_ready,

    // Write address channel
    output mavg_pkg::mavg_burst_t aw_req,
    output logic                  aw_valid,
    input  logic                  aw_ready,

    // Read data channel
    input  mavg_pkg::mavg_beat_t  rd,
    input  logic                  rvalid,
    output logic                  rready,

    // Write data channel
    output mavg_pkg::mavg_beat_t  wr,
    output logic                  wvalid,
    input  logic                  wready
);

    // Window between buffer and averager
    logic [`MAVG_WIN_LEN-1:0][`MAVG_DATA_W-1:0] win;
    logic                                       win_valid;
    logic                                       win_last;
    logic                                       win_take;

    // Address side
    mavg_cmd_issue u_cmd_issue (
        .clk(clk), .rst_q(rst_q),
        .cmd_valid(cmd_valid), .cmd(cmd), .cmd_rdy(cmd_rdy),
        .ar_req(ar_req), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .aw_req(aw_req), .aw_valid(aw_valid), .aw_ready(aw_ready)
    );

    // Sample window on read data
    mavg_window u_window (
        .clk(clk), .rst_q(rst_q),
        .rvalid(rvalid), .rd(rd), .rready(rready),
        .win(win), .win_valid(win_valid), .win_last(win_last), .win_take(win_take)
    );

    // Averages out on write data
    mavg_averager u_averager (
        .clk(clk), .rst_q(rst_q),
        .win(win), .win_valid(win_valid), .win_last(win_last), .win_take(win_take),
        .wr(wr), .wvalid(wvalid), .wready(wready)
    );

endmodule

// File: rtl/mavg_averager.sv
`include "mavg_consts.svh"

module mavg_averager (
    input  logic                                       clk,
    input  logic                                       rst_q,

    // Window from the buffer
    input  logic [`MAVG_WIN_LEN-1:0][`MAVG_DATA_W-1:0] win,
    input  logic                                       win_valid,
    input  logic                                       win_last,
    output logic                                       win_take,

    // Write data channel
    output mavg_pkg::mavg_beat_t                       wr,
    output logic                                       wvalid,
    input  logic                                       wready
);

    logic [`MAVG_DATA_W+`MAVG_WIN_LOG2-1:0] sum;        // Full width, no overflow
    logic [`MAVG_DATA_W-1:0]                avg_q;      // Held write data
    logic                                   last_q;     // Held write last
    logic                                   take_nxt;

    // Sum every slot of the window
    always_comb begin
        sum = '0;
        for (int i = 0; i < `MAVG_WIN_LEN; i++) begin
            sum = sum + win[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Claim and hold
    ////////////////////////////////////////////////////////////////////////////

    // Claim once per window and never while a beat waits on wready
    assign take_nxt = win_valid && !win_take && !wvalid;

    always_ff @(posedge clk) begin
        if (rst_q) begin
            win_take <= 1'b0;
            wvalid   <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            win_take <= take_nxt;   // One cycle pulse
            if (win_take) begin
                wvalid <= 1'b1;
                last_q <= win_last;
            end else if (wvalid && wready) begin
                wvalid <= 1'b0;     // Beat accepted downstream
            end
        end
    end

    // Divide by the window length, drop the fraction
    always_ff @(posedge clk) begin
        if (win_take) begin
            avg_q <= sum[`MAVG_DATA_W+`MAVG_WIN_LOG2-1:`MAVG_WIN_LOG2];
        end
    end

    assign wr = '{data: avg_q, last: last_q};

endmodule

// File: rtl/mavg_window.sv
`include "mavg_consts.svh"

module mavg_window (
    input  logic                                       clk,
    input  logic                                       rst_q,

    // Read data channel
    input  logic                                       rvalid,
    input  mavg_pkg::mavg_beat_t                       rd,
    output logic                                       rready,

    // Window to the averager
    output logic [`MAVG_WIN_LEN-1:0][`MAVG_DATA_W-1:0] win,
    output logic                                       win_valid,
    output logic                                       win_last,
    input  logic                                       win_take
);

    logic shift_in;     // Beat accepted this cycle
    logic clear_win;    // Last sample of burst claimed

    ////////////////////////////////////////////////////////////////////////////
    // Read data handshake
    ////////////////////////////////////////////////////////////////////////////

    // Accept a beat only when the newest sample is already claimed
    assign rready   = ~win_valid;
    assign shift_in = rvalid && rready;

    // Burst done, next burst starts from an empty window
    assign clear_win = win_take && win_last;

    ////////////////////////////////////////////////////////////////////////////
    // Shift register window
    ////////////////////////////////////////////////////////////////////////////

    // Slot 0 holds the newest sample
    // Slot WIN_LEN-1 holds the oldest
    always_ff @(posedge clk) begin
        if (rst_q || clear_win) begin
            win       <= '0;        // Zeros stand in for samples before the burst
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else if (shift_in) begin
            // Oldest drops off the top
            win       <= {win[`MAVG_WIN_LEN-2:0], rd.data};
            win_valid <= 1'b1;      // Unclaimed until the averager takes it
            win_last  <= rd.last;
        end else if (win_take) begin
            win_valid <= 1'b0;      // Claimed, keep contents for next sum
        end
    end

endmodule

// File: rtl/mavg_cmd_issue.sv
`include "mavg_consts.svh"

module mavg_cmd_issue (
    input  logic                  clk,
    input  logic                  rst_q,

    // Command stream
    input  logic                  cmd_valid,
    input  mavg_pkg::mavg_cmd_t   cmd,
    output logic                  cmd_rdy,

    // Read address channel
    output mavg_pkg::mavg_burst_t ar_req,
    output logic                  ar_valid,
    input  logic                  ar_ready,

    // Write address channel
    output mavg_pkg::mavg_burst_t aw_req,
    output logic                  aw_valid,
    input  logic                  aw_ready
);

    // Address FSM states, same encoding on both channels
    localparam logic IDLE  = 1'b0;     // Waiting for a command
    localparam logic ISSUE = 1'b1;     // Request on the bus

    logic                    ar_state;
    logic                    aw_state;
    logic                    cmd_xfer;      // Command taken this cycle
    logic [`MAVG_SIZE_W-1:0] beat_cnt;      // Size in beats
    logic [`MAVG_LEN_W-1:0]  burst_len;     // Bus length encoding

    // Shared next state rule for both address FSMs
    function automatic logic next_state(
        input logic state,
        input logic start,
        input logic ready
    );
        logic nxt;
        nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nxt = ISSUE;    // New command loaded
                end
            end
            ISSUE: begin
                if (ready) begin
                    nxt = IDLE;     // Slave took the request
                end
            end
        endcase
        return nxt;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Command acceptance
    ////////////////////////////////////////////////////////////////////////////

    // Only take a command once both channels are done with the last one
    assign cmd_rdy  = (ar_state == IDLE) && (aw_state == IDLE);
    assign cmd_xfer = cmd_valid && cmd_rdy;

    // Bytes to beats, then minus one for the len field
    assign beat_cnt  = cmd.size >> `MAVG_BEAT_LOG2;
    assign burst_len = beat_cnt[`MAVG_LEN_W-1:0] - 1'b1;

    // Request words, only change on command transfer
    always_ff @(posedge clk) begin
        if (cmd_xfer) begin
            ar_req.addr <= cmd.src_addr;
            ar_req.len  <= burst_len;
            aw_req.addr <= cmd.dst_addr;
            aw_req.len  <= burst_len;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address FSMs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_q) begin
            ar_state <= IDLE;
            aw_state <= IDLE;
        end else begin
            ar_state <= next_state(ar_state, cmd_xfer, ar_ready);  // Read side
            aw_state <= next_state(aw_state, cmd_xfer, aw_ready);  // Write side
        end
    end

    // Valid straight from state, held until own ready
    assign ar_valid = (ar_state == ISSUE);
    assign aw_valid = (aw_state == ISSUE);

endmodule

// File: rtl/mavg_pkg.sv
`include "mavg_consts.svh"

package mavg_pkg;

    // Command from the host stream
    typedef struct packed {
        logic [`MAVG_SIZE_W-1:0] size;      // Bytes to process
        logic [`MAVG_ADDR_W-1:0] dst_addr;  // Where averages go
        logic [`MAVG_ADDR_W-1:0] src_addr;  // Where samples come from
    } mavg_cmd_t;

    // Burst request on the read or write address channel
    typedef struct packed {
        logic [`MAVG_ADDR_W-1:0] addr;      // Start byte address
        logic [`MAVG_LEN_W-1:0]  len;       // Beats minus one
    } mavg_burst_t;

    // Data beat, read or write side
    typedef struct packed {
        logic [`MAVG_DATA_W-1:0] data;
        logic                    last;      // Final beat of burst
    } mavg_beat_t;

endpackage

// File: include/mavg_consts.svh
`ifndef MAVG_CONSTS_SVH
`define MAVG_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Byte address on both memory channels
`define MAVG_ADDR_W     32
`define MAVG_SIZE_W     32      // Command size field in bytes
`define MAVG_DATA_W     32      // One sample per beat
`define MAVG_LEN_W      8       // Burst length field, beats minus one

////////////////////////////////////////////////////////////////////////////
// Averaging window
////////////////////////////////////////////////////////////////////////////

// Samples summed per output, power of two only
`define MAVG_WIN_LEN    4
// Divide shift and extra sum bits
`define MAVG_WIN_LOG2   2

// Bytes per beat as a shift
`define MAVG_BEAT_LOG2  2

`endif
